// File: source/filter_geom_pkg.sv
// median filter geometry
// image size, window shape, line ring depth and pipeline depth
`default_nettype none

package filter_geom_pkg;

  // image, square and 8-bit grayscale
  localparam int img_w = 128;
  localparam int img_h = 128;
  localparam int pos_w = $clog2(img_w);
  localparam int pix_w = 8;
  localparam logic [pix_w-1:0] pix_max = '1;

  // 7x7 window around the centre pixel
  localparam int win_size = 7;
  localparam int win_half = 3;
  localparam int win_taps = win_size * win_size;
  localparam int med_rank = win_taps / 2;

  // line ring in the RAM
  localparam int ring_lines = 8;
  localparam int line_w = $clog2(ring_lines);
  localparam int prefill_lines = 4;

  // signed tap coordinate, wide enough for -3 .. img_w+3
  localparam int coord_w = 9;

  // RAM read, pair assembly, cell update
  localparam int fetch_drain = 3;

endpackage

`default_nettype wire

// File: source/filter_bus_pkg.sv
// median filter buses
// tap requests from the controller, RAM address and sorter operation
`default_nettype none

package filter_bus_pkg;

  typedef enum logic [2:0] {
    op_none,
    op_write,
    op_clear,
    op_load,
    op_drop,
    op_add
  } tap_op_e;

  // one window tap or one pixel write
  typedef struct packed {
    tap_op_e op;
    logic signed [filter_geom_pkg::coord_w-1:0] row;
    logic signed [filter_geom_pkg::coord_w-1:0] col;
  } tap_req_t;

  // ring line in the upper bits, column in the lower bits
  typedef union packed {
    logic [filter_geom_pkg::line_w+filter_geom_pkg::pos_w-1:0] flat;
    struct packed {
      logic [filter_geom_pkg::line_w-1:0] line;
      logic [filter_geom_pkg::pos_w-1:0]  col;
    } split;
  } ram_addr_u;

  typedef struct packed {
    logic en;
    logic clr;
    logic [filter_geom_pkg::pix_w-1:0] ins;
    logic [filter_geom_pkg::pix_w-1:0] del;
  } sort_op_t;

endpackage

`default_nettype wire

// File: source/rank_cell.sv
// one slot of the rank sorter
// shifts toward the removed value's slot and takes the inserted value
// where the order requires it
`timescale 1ns/1ns
`default_nettype none

module rank_cell (
  input  wire                                CLK,
  input  wire                                RST,
  input  filter_bus_pkg::sort_op_t           sort_op,
  input  wire [filter_geom_pkg::pix_w-1:0]   prev_val,
  input  wire [filter_geom_pkg::pix_w-1:0]   next_val,
  output logic [filter_geom_pkg::pix_w-1:0]  val
);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      val <= filter_geom_pkg::pix_max;
    end else if (sort_op.clr) begin
      val <= filter_geom_pkg::pix_max;
    end else if (sort_op.en) begin
      if (sort_op.ins < sort_op.del) begin
        // slots in (ins, del] move up by one
        if (val > sort_op.ins && val <= sort_op.del) begin
          val <= (prev_val > sort_op.ins) ? prev_val : sort_op.ins;
        end
      end else if (sort_op.ins > sort_op.del) begin
        // slots in [del, ins) move down by one
        if (val < sort_op.ins && val >= sort_op.del) begin
          val <= (next_val < sort_op.ins) ? next_val : sort_op.ins;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rank_sorter.sv
// rank sorter holding the 49 window values in ascending order
// one remove/insert per cycle, median read from the middle slot
`timescale 1ns/1ns
`default_nettype none

module rank_sorter (
  input  wire                                CLK,
  input  wire                                RST,
  input  filter_bus_pkg::sort_op_t           sort_op,
  output logic [filter_geom_pkg::pix_w-1:0]  median
);

  // chain[0] and the top entry are fixed bounds, slot i sits at chain[i+1]
  wire [filter_geom_pkg::pix_w-1:0] chain [0:filter_geom_pkg::win_taps+1];

  assign chain[0] = '0;
  assign chain[filter_geom_pkg::win_taps+1] = filter_geom_pkg::pix_max;

  for (genvar i = 0; i < filter_geom_pkg::win_taps; i++) begin : g_cell
    rank_cell rank_cell_inst (
      .CLK      (CLK),
      .RST      (RST),
      .sort_op  (sort_op),
      .prev_val (chain[i]),
      .next_val (chain[i+2]),
      .val      (chain[i+1])
    );
  end

  assign median = chain[filter_geom_pkg::med_rank+1];

endmodule

`default_nettype wire

// File: source/line_ram.sv
// line ring storage, 1024x8 single-port RAM
// synchronous write, registered read
`timescale 1ns/1ns
`default_nettype none

module line_ram (
  input  wire                                CLK,
  input  wire                                en,
  input  wire                                we,
  input  filter_bus_pkg::ram_addr_u          addr,
  input  wire [filter_geom_pkg::pix_w-1:0]   d,
  output logic [filter_geom_pkg::pix_w-1:0]  q
);

  logic [filter_geom_pkg::pix_w-1:0] mem [0:filter_geom_pkg::ring_lines*filter_geom_pkg::img_w-1];

  always_ff @(posedge CLK) begin
    if (en) begin
      if (we) begin
        mem[addr.flat] <= d;
      end else begin
        q <= mem[addr.flat];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/tap_fetch.sv
// tap fetch for the median filter
// maps tap coordinates onto the line ring, pads off-image taps with 0
// and pairs leaving and entering values into sorter operations
`timescale 1ns/1ns
`default_nettype none

module tap_fetch (
  input  wire                                CLK,
  input  wire                                RST,
  input  filter_bus_pkg::tap_req_t           tap_req,
  input  wire [filter_geom_pkg::pix_w-1:0]   wr_data,
  input  wire [filter_geom_pkg::pix_w-1:0]   ram_q,
  output filter_bus_pkg::ram_addr_u          ram_addr,
  output logic [filter_geom_pkg::pix_w-1:0]  ram_d,
  output logic                               ram_en,
  output logic                               ram_we,
  output filter_bus_pkg::sort_op_t           sort_op
);

  filter_bus_pkg::tap_op_e op_q;
  logic pad;
  logic pad_q;
  logic is_read;
  logic en_q;
  logic clr_q;
  logic [filter_geom_pkg::pix_w-1:0] tap_val;
  logic [filter_geom_pkg::pix_w-1:0] drop_val;
  logic [filter_geom_pkg::pix_w-1:0] ins_q;
  logic [filter_geom_pkg::pix_w-1:0] del_q;

  // single bounds test per request
  assign pad = tap_req.row < 0 || tap_req.row >= filter_geom_pkg::img_h ||
               tap_req.col < 0 || tap_req.col >= filter_geom_pkg::img_w;

  assign is_read = tap_req.op inside {filter_bus_pkg::op_load, filter_bus_pkg::op_drop,
                                      filter_bus_pkg::op_add};

  always_comb begin
    // image row y lives in ring line y mod 8
    ram_addr.split.line = tap_req.row[filter_geom_pkg::line_w-1:0];
    ram_addr.split.col  = tap_req.col[filter_geom_pkg::pos_w-1:0];
    ram_we = tap_req.op == filter_bus_pkg::op_write;
    ram_en = ram_we || (is_read && !pad);
    ram_d  = wr_data;
  end

  // read data is one cycle behind the request
  assign tap_val = pad_q ? '0 : ram_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op_q  <= filter_bus_pkg::op_none;
      en_q  <= 1'b0;
      clr_q <= 1'b0;
    end else begin
      op_q  <= tap_req.op;
      en_q  <= op_q == filter_bus_pkg::op_load || op_q == filter_bus_pkg::op_add;
      clr_q <= op_q == filter_bus_pkg::op_clear;
    end
  end

  always_ff @(posedge CLK) begin
    pad_q <= pad;
    ins_q <= tap_val;
    // a load replaces one of the empty slots
    del_q <= (op_q == filter_bus_pkg::op_load) ? filter_geom_pkg::pix_max : drop_val;
    if (op_q == filter_bus_pkg::op_drop) begin
      drop_val <= tap_val;
    end
  end

  assign sort_op = '{en: en_q, clr: clr_q, ins: ins_q, del: del_q};

endmodule

`default_nettype wire

// File: source/filter_ctrl.sv
// frame controller for the median filter
// accepts input lines into the ring, walks the output raster,
// issues one tap request per cycle and registers each median
`timescale 1ns/1ns
`default_nettype none

module filter_ctrl (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire                                in_en,
  input  wire [filter_geom_pkg::pix_w-1:0]   din,
  input  wire [filter_geom_pkg::pix_w-1:0]   median,
  output filter_bus_pkg::tap_req_t           tap_req,
  output logic [filter_geom_pkg::pix_w-1:0]  wr_data,
  output logic                               busy,
  output logic                               out_valid,
  output logic [filter_geom_pkg::pix_w-1:0]  dout
);

  typedef enum logic [2:0] {
    st_prefill,
    st_row_start,
    st_slide,
    st_drain,
    st_fill,
    st_done
  } state_e;

  state_e state;

  logic [filter_geom_pkg::pos_w-1:0] in_row;
  logic [filter_geom_pkg::pos_w-1:0] in_col;
  logic [filter_geom_pkg::pos_w-1:0] out_row;
  logic [filter_geom_pkg::pos_w-1:0] out_col;
  logic [$clog2(filter_geom_pkg::win_taps+1)-1:0] tap_cnt;
  logic [$clog2(filter_geom_pkg::win_size)-1:0]   win_r;
  logic [$clog2(filter_geom_pkg::win_size)-1:0]   win_c;
  logic [$clog2(filter_geom_pkg::fetch_drain)-1:0] drain_cnt;
  logic accept;
  logic last_tap;

  assign accept  = in_en && !busy;
  assign wr_data = din;

  // full reload takes clear plus 49 loads, a slide takes 7 drop/add pairs
  assign last_tap = (state == st_row_start && tap_cnt == filter_geom_pkg::win_taps) ||
                    (state == st_slide && tap_cnt == 2 * filter_geom_pkg::win_size - 1);

  always_comb begin : tap_gen
    int row_i;
    int col_i;
    row_i = int'(out_row) + int'(win_r) - filter_geom_pkg::win_half;
    col_i = int'(out_col) + int'(win_c) - filter_geom_pkg::win_half;
    tap_req = '0;
    if (accept) begin
      tap_req.op = filter_bus_pkg::op_write;
      row_i = int'(in_row);
      col_i = int'(in_col);
    end else begin
      case (state)
        st_row_start: begin
          tap_req.op = (tap_cnt == 0) ? filter_bus_pkg::op_clear
                                      : filter_bus_pkg::op_load;
        end
        st_slide: begin
          // odd taps enter at c+3, even taps leave at c-4
          tap_req.op = tap_cnt[0] ? filter_bus_pkg::op_add : filter_bus_pkg::op_drop;
          col_i = int'(out_col) + (tap_cnt[0] ? filter_geom_pkg::win_half
                                              : -filter_geom_pkg::win_half - 1);
        end
        default: tap_req.op = filter_bus_pkg::op_none;
      endcase
    end
    tap_req.row = row_i[filter_geom_pkg::coord_w-1:0];
    tap_req.col = col_i[filter_geom_pkg::coord_w-1:0];
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_prefill;
      in_row    <= '0;
      in_col    <= '0;
      out_row   <= '0;
      out_col   <= '0;
      tap_cnt   <= '0;
      win_r     <= '0;
      win_c     <= '0;
      drain_cnt <= '0;
      busy      <= 1'b0;
      out_valid <= 1'b0;
      dout      <= '0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        st_prefill, st_fill: begin
          // busy is still high for one cycle after the last median of a row
          if (busy) begin
            busy <= 1'b0;
          end else if (accept) begin
            in_col <= in_col + 1'b1;
            if (in_col == filter_geom_pkg::img_w - 1) begin
              in_row <= in_row + 1'b1;
              if (state == st_fill || in_row == filter_geom_pkg::prefill_lines - 1) begin
                busy  <= 1'b1;
                state <= st_row_start;
              end
            end
          end
        end
        st_row_start: begin
          tap_cnt <= tap_cnt + 1'b1;
          if (tap_cnt != 0) begin
            if (win_c == filter_geom_pkg::win_size - 1) begin
              win_c <= '0;
              win_r <= win_r + 1'b1;
            end else begin
              win_c <= win_c + 1'b1;
            end
          end
          if (last_tap) begin
            drain_cnt <= '0;
            state     <= st_drain;
          end
        end
        st_slide: begin
          tap_cnt <= tap_cnt + 1'b1;
          if (tap_cnt[0]) begin
            win_r <= win_r + 1'b1;
          end
          if (last_tap) begin
            drain_cnt <= '0;
            state     <= st_drain;
          end
        end
        st_drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == filter_geom_pkg::fetch_drain - 1) begin
            out_valid <= 1'b1;
            dout      <= median;
            tap_cnt   <= '0;
            win_r     <= '0;
            if (out_col != filter_geom_pkg::img_w - 1) begin
              out_col <= out_col + 1'b1;
              state   <= st_slide;
            end else if (out_row == filter_geom_pkg::img_h - 1) begin
              state <= st_done;
            end else begin
              out_col <= '0;
              out_row <= out_row + 1'b1;
              // fetch line r+4 only while it exists
              state <= (out_row < filter_geom_pkg::img_h - filter_geom_pkg::prefill_lines)
                       ? st_fill : st_row_start;
            end
          end
        end
        default: begin
          // frame finished, wait for reset
          state <= st_done;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/median_filter_top.sv
// 7x7 streaming median filter, 128x128 8-bit frame
// control, tap fetch, line ring RAM and rank sorter
`timescale 1ns/1ns
`default_nettype none

module median_filter_top (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire                                in_en,
  input  wire [filter_geom_pkg::pix_w-1:0]   din,
  output logic                               busy,
  output logic                               out_valid,
  output logic [filter_geom_pkg::pix_w-1:0]  dout
);

  filter_bus_pkg::tap_req_t        tap_req;
  filter_bus_pkg::ram_addr_u       ram_addr;
  filter_bus_pkg::sort_op_t        sort_op;
  logic [filter_geom_pkg::pix_w-1:0] wr_data;
  logic [filter_geom_pkg::pix_w-1:0] ram_d;
  logic [filter_geom_pkg::pix_w-1:0] ram_q;
  logic [filter_geom_pkg::pix_w-1:0] median;
  logic                            ram_en;
  logic                            ram_we;

  filter_ctrl filter_ctrl_inst (
    .CLK       (CLK),
    .RST       (RST),
    .in_en     (in_en),
    .din       (din),
    .median    (median),
    .tap_req   (tap_req),
    .wr_data   (wr_data),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout)
  );

  tap_fetch tap_fetch_inst (
    .CLK      (CLK),
    .RST      (RST),
    .tap_req  (tap_req),
    .wr_data  (wr_data),
    .ram_q    (ram_q),
    .ram_addr (ram_addr),
    .ram_d    (ram_d),
    .ram_en   (ram_en),
    .ram_we   (ram_we),
    .sort_op  (sort_op)
  );

  line_ram line_ram_inst (
    .CLK  (CLK),
    .en   (ram_en),
    .we   (ram_we),
    .addr (ram_addr),
    .d    (ram_d),
    .q    (ram_q)
  );

  rank_sorter rank_sorter_inst (
    .CLK     (CLK),
    .RST     (RST),
    .sort_op (sort_op),
    .median  (median)
  );

endmodule

`default_nettype wire

// File: bench/filter_asserts.sv
// port checks for the median filter top level
// out_valid only while busy, quiet after reset, dout held between pulses
`timescale 1ns/1ns
`default_nettype none

module filter_asserts (
  input wire                               CLK,
  input wire                               RST,
  input wire                               busy,
  input wire                               out_valid,
  input wire [filter_geom_pkg::pix_w-1:0]  dout
);

  // medians only leave while input is held off
  valid_needs_busy: assert property (
    @(posedge CLK) disable iff (RST) out_valid |-> busy
  ) else $error("out_valid high while busy is low");

  // first full cycle after release, not the release cycle itself
  idle_after_reset: assert property (
    @(posedge CLK) $fell(RST) |=> !busy && !out_valid
  ) else $error("busy or out_valid high right after reset release");

  dout_held: assert property (
    @(posedge CLK) disable iff (RST) !out_valid |-> $stable(dout)
  ) else $error("dout changed without an out_valid pulse");

endmodule

bind median_filter_top filter_asserts filter_asserts_inst (
  .CLK       (CLK),
  .RST       (RST),
  .busy      (busy),
  .out_valid (out_valid),
  .dout      (dout)
);

`default_nettype wire

// File: bench/tb_median_filter.sv
// testbench for the 7x7 median filter
// streams a random frame and an all-255 frame with random input gaps
// and checks every median against a sorting model of the window
`timescale 1ns/1ns
`default_nettype none

module tb_median_filter;

  localparam int frame_px = filter_geom_pkg::img_w * filter_geom_pkg::img_h;
  localparam int prefill_px = filter_geom_pkg::prefill_lines * filter_geom_pkg::img_w;
  localparam int stall_limit = 1000;

  logic CLK;
  logic RST;
  logic in_en;
  logic [filter_geom_pkg::pix_w-1:0] din;
  wire busy;
  wire out_valid;
  wire [filter_geom_pkg::pix_w-1:0] dout;

  logic [filter_geom_pkg::pix_w-1:0] frame_mem [0:frame_px-1];
  integer seed;

  median_filter_top median_filter_top_inst (
    .CLK       (CLK),
    .RST       (RST),
    .in_en     (in_en),
    .din       (din),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("ERR %0t: %s, got %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // median of the window with off-image taps as 0
  function automatic int window_median(input int r, input int c);
    int vals [filter_geom_pkg::win_taps];
    int n;
    int key;
    int j;
    n = 0;
    for (int dr = -filter_geom_pkg::win_half; dr <= filter_geom_pkg::win_half; dr++) begin
      for (int dc = -filter_geom_pkg::win_half; dc <= filter_geom_pkg::win_half; dc++) begin
        if (r + dr >= 0 && r + dr < filter_geom_pkg::img_h &&
            c + dc >= 0 && c + dc < filter_geom_pkg::img_w) begin
          vals[n] = int'(frame_mem[(r + dr) * filter_geom_pkg::img_w + c + dc]);
        end else begin
          vals[n] = 0;
        end
        n++;
      end
    end
    // ascending insertion sort
    for (int i = 1; i < n; i++) begin
      key = vals[i];
      j = i - 1;
      while (j >= 0 && vals[j] > key) begin
        vals[j + 1] = vals[j];
        j--;
      end
      vals[j + 1] = key;
    end
    return vals[filter_geom_pkg::med_rank];
  endfunction

  // called 1 ns after a rising edge or at time 0
  task automatic apply_reset();
    RST = 1'b1;
    in_en = 1'b0;
    repeat (10) begin
      @(posedge CLK);
      #1;
      check_value(int'(busy), 0, "busy during reset");
      check_value(int'(out_valid), 0, "out_valid during reset");
    end
    RST = 1'b0;
  endtask

  task automatic run_frame(input bit all_max);
    int accepted;
    int out_idx;
    int stall;
    int rr;
    int cc;
    bit pending;
    logic [31:0] rnd;
    accepted = 0;
    out_idx = 0;
    stall = 0;
    for (int i = 0; i < frame_px; i++) begin
      rnd = $random(seed);
      frame_mem[i] = all_max ? filter_geom_pkg::pix_max : rnd[7:0];
    end
    while (out_idx < frame_px) begin
      rnd = $random(seed);
      pending = 1'b0;
      din = rnd[15:8];
      if (!busy && accepted < frame_px) begin
        // roughly three in four cycles offer a pixel
        in_en = rnd[1:0] != 2'b00;
        pending = in_en;
        if (in_en) begin
          din = frame_mem[accepted];
        end
      end else begin
        in_en = 1'b0;
      end
      @(posedge CLK);
      #1;
      stall++;
      if (pending) begin
        accepted++;
        stall = 0;
        // busy rises on the edge that takes the last pixel of a batch
        if (accepted >= prefill_px && accepted % filter_geom_pkg::img_w == 0) begin
          check_value(int'(busy), 1, "busy after a full input batch");
        end
      end
      if (accepted < prefill_px) begin
        check_value(int'(busy), 0, "busy during prefill");
      end else if (!busy) begin
        // input window is open only for line r+4 after row r
        check_value(int'(accepted < frame_px), 1, "busy low after the last line");
        check_value(accepted / filter_geom_pkg::img_w,
                    out_idx / filter_geom_pkg::img_w + filter_geom_pkg::prefill_lines - 1,
                    "input line while busy is low");
      end
      if (out_valid) begin
        check_value(int'(accepted >= prefill_px), 1, "out_valid before prefill done");
        rr = out_idx / filter_geom_pkg::img_w;
        cc = out_idx % filter_geom_pkg::img_w;
        check_value(int'(dout), window_median(rr, cc),
                    $sformatf("median at row %0d col %0d", rr, cc));
        out_idx++;
        stall = 0;
      end
      if (stall > stall_limit) begin
        $display("timeout: no pixel taken and no median out for %0d cycles, %0d outputs seen",
                 stall_limit, out_idx);
        abort_run();
      end
    end
    check_value(accepted, frame_px, "pixels accepted in the frame");
  endtask

  // after the frame the filter stays quiet with busy held
  task automatic idle_after_frame();
    logic [31:0] rnd;
    repeat (200) begin
      rnd = $random(seed);
      in_en = rnd[0];
      din = rnd[15:8];
      @(posedge CLK);
      #1;
      check_value(int'(out_valid), 0, "out_valid after the last output");
      check_value(int'(busy), 1, "busy after the last output");
    end
    in_en = 1'b0;
  endtask

  initial begin
    seed = 5368;
    RST = 1'b1;
    in_en = 1'b0;
    din = '0;
    apply_reset();
    run_frame(1'b0);
    idle_after_frame();
    apply_reset();
    run_frame(1'b1);
    idle_after_frame();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
source/filter_geom_pkg.sv
source/filter_bus_pkg.sv
source/rank_cell.sv
source/rank_sorter.sv
source/line_ram.sv
source/tap_fetch.sv
source/filter_ctrl.sv
source/median_filter_top.sv
bench/filter_asserts.sv
bench/tb_median_filter.sv

// File: run.sh
#!/bin/sh
# build the median filter testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f \
  --top-module tb_median_filter -o tb_sim &&
./obj_dir/tb_sim || exit 1
